// ==== hw/oq_settings.svh ====
`ifndef OQ_SETTINGS_SVH
`define OQ_SETTINGS_SVH

// stream word
`define OQ_DATA_W 32
// one enable bit per byte
`define OQ_KEEP_W 4
// packet rank
`define OQ_RANK_W 8

// shared packet buffer
`define OQ_BUF_DEPTH 64
`define OQ_ADDR_W 6

// sorted scheduler entries
`define OQ_SCHED_DEPTH 8

// remaining words at or below this raise almost full
`define OQ_ALMOST_FULL 8

`endif

// ==== hw/oq_pkg.sv ====
`default_nettype none

`include "oq_settings.svh"

package oq_pkg;

    // payload fields
    typedef logic [`OQ_DATA_W-1:0] oq_data_t;
    typedef logic [`OQ_KEEP_W-1:0] oq_keep_t;
    typedef logic [`OQ_RANK_W-1:0] oq_rank_t;

    // buffer address
    typedef logic [`OQ_ADDR_W-1:0] oq_addr_t;
    // one bit wider so the full depth fits
    typedef logic [`OQ_ADDR_W:0]   oq_count_t;

    // dequeue fsm states
    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        SEND
    } oq_state_e;

endpackage

`default_nettype wire

// ==== hw/oq_pkt_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "oq_settings.svh"

module oq_pkt_buffer
    import oq_pkg::*;
(
    input  wire logic     axis_aclk,
    input  wire logic     axis_resetn,
    input  wire logic     wr_valid,
    input  wire oq_data_t wr_data,
    input  wire oq_keep_t wr_keep,
    input  wire logic     wr_last,
    input  wire logic     rd_en,
    input  wire oq_addr_t rd_addr,
    output logic          wr_accept,
    output oq_addr_t      wr_addr,
    output logic          has_free,
    output oq_data_t      rd_data,
    output oq_keep_t      rd_keep,
    output logic          rd_last,
    output oq_addr_t      rd_next
);

    localparam int DEPTH = `OQ_BUF_DEPTH;

    // word storage
    oq_data_t data_mem [DEPTH];
    oq_keep_t keep_mem [DEPTH];
    logic     last_mem [DEPTH];
    // successor of each address
    oq_addr_t link_mem [DEPTH];

    // free list
    oq_addr_t  fl_head;
    oq_addr_t  fl_tail;
    oq_count_t free_cnt;
    oq_addr_t  head_next;

    assign has_free  = (free_cnt != '0);
    assign wr_accept = wr_valid & has_free;
    // new words go to the free list head
    assign wr_addr   = fl_head;

    ////////////////////////////////////////
    // free list head and tail
    ////////////////////////////////////////

    always_comb
    begin
        head_next = fl_head;
        if (wr_accept && rd_en)
        begin
            // last free word taken while one comes back
            head_next = (free_cnt == oq_count_t'(1)) ? rd_addr : link_mem[fl_head];
        end
        else if (wr_accept)
        begin
            head_next = link_mem[fl_head];
        end
        else if (rd_en && !has_free)
        begin
            // list was empty
            head_next = rd_addr;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            fl_head  <= '0;
            fl_tail  <= oq_addr_t'(DEPTH - 1);
            free_cnt <= oq_count_t'(DEPTH);
        end
        else
        begin
            fl_head <= head_next;
            // freed word joins at the tail
            if (rd_en)
            begin
                fl_tail <= rd_addr;
            end
            case ({wr_accept, rd_en})
                2'b10:   free_cnt <= free_cnt - 1'b1;
                2'b01:   free_cnt <= free_cnt + 1'b1;
                default: free_cnt <= free_cnt;
            endcase
        end
    end

    // chain 0 -> 1 -> ... -> 63 on reset
    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            for (int i = 0; i < DEPTH; i++)
            begin
                link_mem[i] <= oq_addr_t'(i + 1);
            end
        end
        else if (rd_en)
        begin
            link_mem[fl_tail] <= rd_addr;
        end
    end

    ////////////////////////////////////////
    // word write and read
    ////////////////////////////////////////

    always_ff @(posedge axis_aclk)
    begin
        if (wr_accept)
        begin
            data_mem[fl_head] <= wr_data;
            keep_mem[fl_head] <= wr_keep;
            last_mem[fl_head] <= wr_last;
        end
    end

    // word and its link one cycle after rd_en
    always_ff @(posedge axis_aclk)
    begin
        if (rd_en)
        begin
            rd_data <= data_mem[rd_addr];
            rd_keep <= keep_mem[rd_addr];
            rd_last <= last_mem[rd_addr];
            rd_next <= link_mem[rd_addr];
        end
    end

    // top ready must drop before the free list runs dry
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        wr_valid |-> has_free);

endmodule

`default_nettype wire

// ==== hw/oq_rank_scheduler.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "oq_settings.svh"

module oq_rank_scheduler
    import oq_pkg::*;
(
    input  wire logic     axis_aclk,
    input  wire logic     axis_resetn,
    input  wire logic     wr_accept,
    input  wire oq_addr_t wr_addr,
    input  wire logic     wr_last,
    input  wire oq_rank_t wr_rank,
    input  wire logic     pop,
    output logic          sched_valid,
    output logic          sched_full,
    output oq_addr_t      head_addr,
    output oq_rank_t      head_rank
);

    localparam int DEPTH = `OQ_SCHED_DEPTH;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // sorted entries, lowest rank at 0
    oq_addr_t         ent_addr [DEPTH];
    oq_rank_t         ent_rank [DEPTH];
    logic [CNT_W-1:0] ent_cnt;

    // first word capture
    logic     in_pkt;
    oq_addr_t start_addr;
    oq_rank_t start_rank;

    logic             insert;
    oq_addr_t         ins_addr;
    oq_rank_t         ins_rank;
    logic [CNT_W-1:0] ins_pos;
    oq_addr_t         base_addr [DEPTH];
    oq_rank_t         base_rank [DEPTH];
    logic [CNT_W-1:0] base_cnt;
    oq_addr_t         nxt_addr [DEPTH];
    oq_rank_t         nxt_rank [DEPTH];

    assign insert   = wr_accept & wr_last;
    // single word packet uses the live values
    assign ins_addr = in_pkt ? start_addr : wr_addr;
    assign ins_rank = in_pkt ? start_rank : wr_rank;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            in_pkt <= 1'b0;
        end
        else if (wr_accept)
        begin
            in_pkt <= !wr_last;
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (wr_accept && !in_pkt)
        begin
            start_addr <= wr_addr;
            start_rank <= wr_rank;
        end
    end

    ////////////////////////////////////////
    // pop then insert in one step
    ////////////////////////////////////////

    always_comb
    begin
        // array as seen after the pop
        for (int i = 0; i < DEPTH - 1; i++)
        begin
            base_addr[i] = pop ? ent_addr[i + 1] : ent_addr[i];
            base_rank[i] = pop ? ent_rank[i + 1] : ent_rank[i];
        end
        base_addr[DEPTH-1] = ent_addr[DEPTH-1];
        base_rank[DEPTH-1] = ent_rank[DEPTH-1];
        base_cnt           = ent_cnt - CNT_W'(pop);

        // slot after all equal or lower ranks
        ins_pos = '0;
        for (int i = 0; i < DEPTH; i++)
        begin
            if (i < int'(base_cnt) && base_rank[i] <= ins_rank)
            begin
                ins_pos = ins_pos + 1'b1;
            end
        end

        for (int i = 0; i < DEPTH; i++)
        begin
            nxt_addr[i] = base_addr[i];
            nxt_rank[i] = base_rank[i];
        end
        if (insert)
        begin
            // shift the higher ranks up one
            for (int i = 1; i < DEPTH; i++)
            begin
                if (i > int'(ins_pos))
                begin
                    nxt_addr[i] = base_addr[i - 1];
                    nxt_rank[i] = base_rank[i - 1];
                end
            end
            for (int i = 0; i < DEPTH; i++)
            begin
                if (i == int'(ins_pos))
                begin
                    nxt_addr[i] = ins_addr;
                    nxt_rank[i] = ins_rank;
                end
            end
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            ent_cnt <= '0;
        end
        else
        begin
            ent_cnt <= base_cnt + CNT_W'(insert);
        end
    end

    always_ff @(posedge axis_aclk)
    begin
        if (insert || pop)
        begin
            ent_addr <= nxt_addr;
            ent_rank <= nxt_rank;
        end
    end

    assign sched_valid = (ent_cnt != '0);
    assign sched_full  = (ent_cnt == CNT_W'(DEPTH));
    assign head_addr   = ent_addr[0];
    assign head_rank   = ent_rank[0];

    // input ready holds off inserts while full
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        insert |-> !sched_full);

    // fsm pops only a visible head
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        pop |-> sched_valid);

endmodule

`default_nettype wire

// ==== hw/oq_dequeue_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module oq_dequeue_fsm
    import oq_pkg::*;
(
    input  wire logic     axis_aclk,
    input  wire logic     axis_resetn,
    input  wire logic     sched_valid,
    input  wire oq_addr_t head_addr,
    input  wire oq_rank_t head_rank,
    input  wire oq_data_t rd_data,
    input  wire oq_keep_t rd_keep,
    input  wire logic     rd_last,
    input  wire oq_addr_t rd_next,
    input  wire logic     m_axis_tready,
    output logic          pop,
    output logic          rd_en,
    output oq_addr_t      rd_addr,
    output logic          m_axis_tvalid,
    output oq_data_t      m_axis_tdata,
    output oq_keep_t      m_axis_tkeep,
    output logic          m_axis_tlast,
    output oq_rank_t      m_axis_trank
);

    oq_state_e state;
    oq_state_e state_next;
    // word pointer inside the current packet
    oq_addr_t  cur_addr;
    oq_addr_t  cur_addr_next;
    oq_rank_t  cur_rank;
    logic      out_valid_next;
    logic      xfer;

    assign xfer = m_axis_tvalid & m_axis_tready;

    always_comb
    begin
        state_next     = state;
        cur_addr_next  = cur_addr;
        out_valid_next = m_axis_tvalid;
        pop            = 1'b0;
        rd_en          = 1'b0;
        case (state)
            IDLE:
            begin
                // take the lowest rank packet
                if (sched_valid)
                begin
                    pop           = 1'b1;
                    cur_addr_next = head_addr;
                    state_next    = FETCH;
                end
            end
            FETCH:
            begin
                // one read, word lands on the next edge
                rd_en          = 1'b1;
                out_valid_next = 1'b1;
                state_next     = SEND;
            end
            SEND:
            begin
                // hold until the sink takes it
                if (xfer)
                begin
                    out_valid_next = 1'b0;
                    if (rd_last)
                    begin
                        state_next = IDLE;
                    end
                    else
                    begin
                        // follow the link to the next word
                        cur_addr_next = rd_next;
                        state_next    = FETCH;
                    end
                end
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            state         <= IDLE;
            m_axis_tvalid <= 1'b0;
        end
        else
        begin
            state         <= state_next;
            m_axis_tvalid <= out_valid_next;
        end
    end

    // packet pointer and rank
    always_ff @(posedge axis_aclk)
    begin
        cur_addr <= cur_addr_next;
        if (pop)
        begin
            cur_rank <= head_rank;
        end
    end

    assign rd_addr = cur_addr;

    // read port flops hold the word until the next fetch
    assign m_axis_tdata = rd_data;
    assign m_axis_tkeep = rd_keep;
    assign m_axis_tlast = rd_last;
    assign m_axis_trank = cur_rank;

endmodule

`default_nettype wire

// ==== hw/oq_word_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "oq_settings.svh"

module oq_word_counter
    import oq_pkg::*;
(
    input  wire logic axis_aclk,
    input  wire logic axis_resetn,
    input  wire logic wr_accept,
    input  wire logic rd_en,
    output oq_count_t buffer_remain,
    output logic      buffer_almost_full
);

    // words held in the buffer
    oq_count_t word_cnt;

    always_ff @(posedge axis_aclk)
    begin
        if (!axis_resetn)
        begin
            word_cnt <= '0;
        end
        else
        begin
            case ({wr_accept, rd_en})
                2'b10:   word_cnt <= word_cnt + 1'b1;
                2'b01:   word_cnt <= word_cnt - 1'b1;
                default: word_cnt <= word_cnt;
            endcase
        end
    end

    // free space and threshold
    assign buffer_remain      = oq_count_t'(`OQ_BUF_DEPTH) - word_cnt;
    assign buffer_almost_full = (buffer_remain <= oq_count_t'(`OQ_ALMOST_FULL));

    // input ready and read pacing together keep the count in range
    assert property (@(posedge axis_aclk) disable iff (!axis_resetn)
        word_cnt <= oq_count_t'(`OQ_BUF_DEPTH));

endmodule

`default_nettype wire

// ==== hw/oq_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module oq_top
    import oq_pkg::*;
(
    input  wire logic     axis_aclk,
    input  wire logic     axis_resetn,
    // input stream
    input  wire logic     s_axis_tvalid,
    input  wire oq_data_t s_axis_tdata,
    input  wire oq_keep_t s_axis_tkeep,
    input  wire logic     s_axis_tlast,
    input  wire oq_rank_t s_axis_trank,
    output logic          s_axis_tready,
    // output stream
    output logic          m_axis_tvalid,
    output oq_data_t      m_axis_tdata,
    output oq_keep_t      m_axis_tkeep,
    output logic          m_axis_tlast,
    output oq_rank_t      m_axis_trank,
    input  wire logic     m_axis_tready,
    // status
    output oq_count_t     buffer_remain,
    output logic          buffer_almost_full,
    output logic          sched_full
);

    ////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////

    // write side
    logic     wr_valid;
    logic     wr_accept;
    oq_addr_t wr_addr;
    logic     has_free;

    // scheduler head
    logic     sched_valid;
    oq_addr_t head_addr;
    oq_rank_t head_rank;
    logic     pop;

    // read side
    logic     rd_en;
    oq_addr_t rd_addr;
    oq_data_t rd_data;
    oq_keep_t rd_keep;
    logic     rd_last;
    oq_addr_t rd_next;

    // stall input on no free word or full scheduler
    assign s_axis_tready = has_free & ~sched_full;
    assign wr_valid      = s_axis_tvalid & s_axis_tready;

    ////////////////////////////////////////
    // instances
    ////////////////////////////////////////

    oq_pkt_buffer u_pkt_buffer (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .wr_valid    (wr_valid),
        .wr_data     (s_axis_tdata),
        .wr_keep     (s_axis_tkeep),
        .wr_last     (s_axis_tlast),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .wr_accept   (wr_accept),
        .wr_addr     (wr_addr),
        .has_free    (has_free),
        .rd_data     (rd_data),
        .rd_keep     (rd_keep),
        .rd_last     (rd_last),
        .rd_next     (rd_next)
    );

    oq_rank_scheduler u_rank_scheduler (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .wr_accept   (wr_accept),
        .wr_addr     (wr_addr),
        .wr_last     (s_axis_tlast),
        .wr_rank     (s_axis_trank),
        .pop         (pop),
        .sched_valid (sched_valid),
        .sched_full  (sched_full),
        .head_addr   (head_addr),
        .head_rank   (head_rank)
    );

    oq_dequeue_fsm u_dequeue_fsm (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .sched_valid   (sched_valid),
        .head_addr     (head_addr),
        .head_rank     (head_rank),
        .rd_data       (rd_data),
        .rd_keep       (rd_keep),
        .rd_last       (rd_last),
        .rd_next       (rd_next),
        .m_axis_tready (m_axis_tready),
        .pop           (pop),
        .rd_en         (rd_en),
        .rd_addr       (rd_addr),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tkeep  (m_axis_tkeep),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_trank  (m_axis_trank)
    );

    oq_word_counter u_word_counter (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .wr_accept          (wr_accept),
        .rd_en              (rd_en),
        .buffer_remain      (buffer_remain),
        .buffer_almost_full (buffer_almost_full)
    );

endmodule

`default_nettype wire

// ==== sim/oq_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "oq_settings.svh"

module oq_tb
    import oq_pkg::*;
();

    localparam int NUM_PKTS   = 19;
    localparam int NUM_GROUPS = 5;

    // one packet of the stimulus table
    typedef struct packed {
        logic [3:0] len;
        oq_rank_t   rank;
        logic       hold_ready;
    } pkt_entry_t;

    pkt_entry_t pkt_table [NUM_PKTS];
    int         group_first [NUM_GROUPS];
    int         group_size [NUM_GROUPS];
    string      group_name [NUM_GROUPS];
    // packet indices in expected leave order
    int         exp_order [$];

    logic      axis_aclk;
    logic      axis_resetn;
    logic      s_axis_tvalid;
    oq_data_t  s_axis_tdata;
    oq_keep_t  s_axis_tkeep;
    logic      s_axis_tlast;
    oq_rank_t  s_axis_trank;
    logic      s_axis_tready;
    logic      m_axis_tvalid;
    oq_data_t  m_axis_tdata;
    oq_keep_t  m_axis_tkeep;
    logic      m_axis_tlast;
    oq_rank_t  m_axis_trank;
    logic      m_axis_tready;
    oq_count_t buffer_remain;
    logic      buffer_almost_full;
    logic      sched_full;

    int seed;
    int errors;
    int tests_run;
    int tests_failed;
    int cycle_cnt     = 0;
    int timeout_limit = 0;

    oq_top dut (
        .axis_aclk          (axis_aclk),
        .axis_resetn        (axis_resetn),
        .s_axis_tvalid      (s_axis_tvalid),
        .s_axis_tdata       (s_axis_tdata),
        .s_axis_tkeep       (s_axis_tkeep),
        .s_axis_tlast       (s_axis_tlast),
        .s_axis_trank       (s_axis_trank),
        .s_axis_tready      (s_axis_tready),
        .m_axis_tvalid      (m_axis_tvalid),
        .m_axis_tdata       (m_axis_tdata),
        .m_axis_tkeep       (m_axis_tkeep),
        .m_axis_tlast       (m_axis_tlast),
        .m_axis_trank       (m_axis_trank),
        .m_axis_tready      (m_axis_tready),
        .buffer_remain      (buffer_remain),
        .buffer_almost_full (buffer_almost_full),
        .sched_full         (sched_full)
    );

    ////////////////////////////////////////
    // clock and watchdog
    ////////////////////////////////////////

    initial axis_aclk = 1'b0;
    always #4 axis_aclk = ~axis_aclk;

    always @(posedge axis_aclk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (timeout_limit > 0 && cycle_cnt >= timeout_limit)
        begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////
    // compare tasks
    ////////////////////////////////////////

    task automatic check_data(input string name, input oq_data_t got, input oq_data_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_keep(input string name, input oq_keep_t got, input oq_keep_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_rank(input string name, input oq_rank_t got, input oq_rank_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input oq_count_t got, input oq_count_t exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // stimulus and reference model
    ////////////////////////////////////////

    // word j of packet i
    function automatic oq_data_t word_data(input int pkt, input int word);
        return oq_data_t'(pkt * 256 + word);
    endfunction

    task automatic fill_table();
        // single packet
        pkt_table[0]  = '{len: 4'd4, rank: 8'd20, hold_ready: 1'b1};
        // distinct ranks
        pkt_table[1]  = '{len: 4'd3, rank: 8'd50, hold_ready: 1'b1};
        pkt_table[2]  = '{len: 4'd2, rank: 8'd10, hold_ready: 1'b1};
        pkt_table[3]  = '{len: 4'd5, rank: 8'd40, hold_ready: 1'b1};
        pkt_table[4]  = '{len: 4'd1, rank: 8'd30, hold_ready: 1'b1};
        pkt_table[5]  = '{len: 4'd4, rank: 8'd5,  hold_ready: 1'b1};
        // equal ranks
        pkt_table[6]  = '{len: 4'd2, rank: 8'd7,  hold_ready: 1'b1};
        pkt_table[7]  = '{len: 4'd3, rank: 8'd7,  hold_ready: 1'b1};
        pkt_table[8]  = '{len: 4'd1, rank: 8'd7,  hold_ready: 1'b1};
        // random sink gaps
        pkt_table[9]  = '{len: 4'd6, rank: 8'd3,  hold_ready: 1'b0};
        pkt_table[10] = '{len: 4'd2, rank: 8'd9,  hold_ready: 1'b0};
        pkt_table[11] = '{len: 4'd4, rank: 8'd1,  hold_ready: 1'b0};
        pkt_table[12] = '{len: 4'd3, rank: 8'd3,  hold_ready: 1'b0};
        // deep fill for the occupancy count
        pkt_table[13] = '{len: 4'd6, rank: 8'd12, hold_ready: 1'b1};
        pkt_table[14] = '{len: 4'd6, rank: 8'd4,  hold_ready: 1'b1};
        pkt_table[15] = '{len: 4'd6, rank: 8'd4,  hold_ready: 1'b1};
        pkt_table[16] = '{len: 4'd6, rank: 8'd8,  hold_ready: 1'b1};
        pkt_table[17] = '{len: 4'd6, rank: 8'd2,  hold_ready: 1'b1};
        pkt_table[18] = '{len: 4'd6, rank: 8'd15, hold_ready: 1'b1};
        group_first = '{0, 1, 6, 9, 13};
        group_size  = '{1, 5, 3, 4, 6};
        group_name  = '{"single packet", "rank order", "equal ranks",
                        "random back-pressure", "buffer status"};
    endtask

    // stable sort by rank behind the head already taken
    task automatic build_order(input int g);
        int first;
        int pos;
        first = group_first[g];
        exp_order.delete();
        // idle fsm pops the first packet before the rest are queued
        exp_order.push_back(first);
        for (int i = first + 1; i < first + group_size[g]; i++)
        begin
            pos = 1;
            while (pos < exp_order.size() && pkt_table[exp_order[pos]].rank <= pkt_table[i].rank)
            begin
                pos++;
            end
            exp_order.insert(pos, i);
        end
    endtask

    task automatic send_packet(input int idx);
        int j;
        j = 0;
        while (j < int'(pkt_table[idx].len))
        begin
            @(negedge axis_aclk);
            s_axis_tvalid = 1'b1;
            s_axis_tdata  = word_data(idx, j);
            s_axis_tkeep  = '1;
            s_axis_tlast  = (j == int'(pkt_table[idx].len) - 1);
            // rank only counts on the first word
            s_axis_trank  = (j == 0) ? pkt_table[idx].rank : ~pkt_table[idx].rank;
            // word moves on the coming edge
            if (s_axis_tready)
            begin
                j++;
            end
        end
        @(negedge axis_aclk);
        s_axis_tvalid = 1'b0;
        s_axis_tlast  = 1'b0;
    endtask

    task automatic check_status(input int stored);
        int rem;
        repeat (4) @(negedge axis_aclk);
        rem = `OQ_BUF_DEPTH - stored;
        check_count("buffer_remain", buffer_remain, oq_count_t'(rem));
        check_bit("buffer_almost_full", buffer_almost_full, rem <= `OQ_ALMOST_FULL);
    endtask

    task automatic drain_group();
        int k;
        int w;
        int idx;
        k = 0;
        w = 0;
        while (k < exp_order.size())
        begin
            @(negedge axis_aclk);
            idx = exp_order[k];
            if (pkt_table[idx].hold_ready)
            begin
                m_axis_tready = 1'b1;
            end
            else
            begin
                m_axis_tready = 1'($random(seed));
            end
            if (m_axis_tvalid && m_axis_tready)
            begin
                check_data("m_axis_tdata", m_axis_tdata, word_data(idx, w));
                check_keep("m_axis_tkeep", m_axis_tkeep, '1);
                check_bit("m_axis_tlast", m_axis_tlast, w == int'(pkt_table[idx].len) - 1);
                check_rank("m_axis_trank", m_axis_trank, pkt_table[idx].rank);
                w++;
                if (w == int'(pkt_table[idx].len))
                begin
                    w = 0;
                    k++;
                end
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int err_before);
        tests_run++;
        if (errors == err_before)
        begin
            $display("test %0d %s: ok", num, name);
        end
        else
        begin
            tests_failed++;
            $display("test %0d %s: failed, %0d errors", num, name, errors - err_before);
        end
    endtask

    task automatic run_group(input int g);
        int err_before;
        int stored;
        err_before = errors;
        stored     = 0;
        build_order(g);
        // sink stalled while the group is queued
        m_axis_tready = 1'b0;
        for (int i = group_first[g]; i < group_first[g] + group_size[g]; i++)
        begin
            send_packet(i);
            stored += int'(pkt_table[i].len);
            // head word already fetched so its slot is free
            check_status(stored - 1);
        end
        drain_group();
        m_axis_tready = 1'b1;
        // no stray or repeated word after the last one
        repeat (6)
        begin
            @(negedge axis_aclk);
            check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        end
        check_count("buffer_remain", buffer_remain, oq_count_t'(`OQ_BUF_DEPTH));
        check_bit("buffer_almost_full", buffer_almost_full, 1'b0);
        check_bit("sched_full", sched_full, 1'b0);
        m_axis_tready = 1'b0;
        report_test(g + 2, group_name[g], err_before);
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////

    initial
    begin
        int total_words;
        int err_before;
        axis_resetn   = 1'b0;
        s_axis_tvalid = 1'b0;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_trank  = '0;
        m_axis_tready = 1'b0;
        seed          = 5;
        errors        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        fill_table();

        // write plus paced drain with margin for gaps
        total_words = 0;
        for (int i = 0; i < NUM_PKTS; i++)
        begin
            total_words += int'(pkt_table[i].len);
        end
        timeout_limit = 4 * total_words * 2 + 200;

        repeat (5) @(negedge axis_aclk);
        axis_resetn = 1'b1;

        // idle after reset
        err_before = errors;
        @(negedge axis_aclk);
        check_bit("m_axis_tvalid", m_axis_tvalid, 1'b0);
        check_bit("s_axis_tready", s_axis_tready, 1'b1);
        check_count("buffer_remain", buffer_remain, oq_count_t'(`OQ_BUF_DEPTH));
        check_bit("buffer_almost_full", buffer_almost_full, 1'b0);
        check_bit("sched_full", sched_full, 1'b0);
        report_test(1, "reset state", err_before);

        for (int g = 0; g < NUM_GROUPS; g++)
        begin
            run_group(g);
        end

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
        begin
            $display(">>> PASS");
        end
        else
        begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/oq_pkg.sv
hw/oq_pkt_buffer.sv
hw/oq_rank_scheduler.sv
hw/oq_dequeue_fsm.sv
hw/oq_word_counter.sv
hw/oq_top.sv
sim/oq_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
mkdir -p build

verilator --binary --timing --timescale 1ns/1ns \
    -f project.f \
    --top-module oq_tb \
    -Mdir build/obj \
    -o oq_sim

./build/obj/oq_sim | tee build/sim.log

if grep -q '^>>> PASS$' build/sim.log; then
    exit 0
else
    exit 1
fi
